//--- Makefile
# Verilator build and run for the write DMA

VERILATOR ?= verilator
TOP       ?= tb_cdma_wr
RTL_TOP   ?= cdma_wr_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/aw_burst_gen.sv
`timescale 1ns/1ps

module aw_burst_gen #(
  parameter int unsigned DATA_BITS = cdma_pkg::AXI_DATA_BITS,
  parameter int unsigned ADDR_BITS = cdma_pkg::AXI_ADDR_BITS,
  parameter int unsigned ID_BITS   = cdma_pkg::AXI_ID_BITS,
  parameter int unsigned BURST_LEN = 16
) (
  input  logic                          aclk,
  input  logic                          aresetn,
  // Command latch
  input  logic                          cmd_start,
  input  logic [ADDR_BITS-1:0]          cmd_addr,
  input  logic [cdma_pkg::LEN_BITS-1:0] cmd_words,
  // Outstanding limit from tracker
  input  logic                          aw_stall,
  output logic                          aw_idle,
  // AW channel
  output logic                          m_axi_awvalid,
  input  logic                          m_axi_awready,
  output logic [ADDR_BITS-1:0]          m_axi_awaddr,
  output logic [ID_BITS-1:0]            m_axi_awid,
  output logic [7:0]                    m_axi_awlen,
  output logic [2:0]                    m_axi_awsize,
  output logic [1:0]                    m_axi_awburst
);
  import cdma_pkg::*;

  localparam int unsigned BYTES_LOG2 = $clog2(DATA_BITS / 8);

  // Progress through the current command
  logic [ADDR_BITS-1:0] next_addr;
  logic [LEN_BITS-1:0]  rem_words;
  logic [LEN_BITS-1:0]  bursts_left;
  // Registered AW beat
  logic                 awvalid_q;
  logic [ADDR_BITS-1:0] awaddr_q;
  logic [7:0]           awlen_q;
  // Next burst candidate
  logic [ADDR_BITS-1:0] cur_addr;
  logic [LEN_BITS-1:0]  cur_words;
  logic [LEN_BITS-1:0]  cur_bursts;
  logic [LEN_BITS-1:0]  burst_words;
  logic                 load;

  //////////////////////////////////////////////////
  // Burst selection
  //////////////////////////////////////////////////

  // Bypass on the strobe so the first burst is out one cycle later
  always_comb begin
    cur_addr    = cmd_start ? cmd_addr : next_addr;
    cur_words   = cmd_start ? cmd_words : rem_words;
    cur_bursts  = cmd_start ? bursts_of(cmd_words, BURST_LEN) : bursts_left;
    // Short tail burst
    burst_words = (cur_words < LEN_BITS'(BURST_LEN)) ? cur_words : LEN_BITS'(BURST_LEN);
  end

  // Slot free, work left, tracker not full
  assign load = (cur_bursts != '0) && !aw_stall && (!awvalid_q || m_axi_awready);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      awvalid_q   <= 1'b0;
      bursts_left <= '0;
    end else if (load) begin
      awvalid_q   <= 1'b1;
      bursts_left <= cur_bursts - 1'b1;
    end else begin
      if (m_axi_awready) begin
        awvalid_q <= 1'b0;
      end
      // Stalled at launch, park the command
      if (cmd_start) begin
        bursts_left <= cur_bursts;
      end
    end
  end

  // Address and length bookkeeping
  always_ff @(posedge aclk) begin
    if (load) begin
      awaddr_q  <= cur_addr;
      awlen_q   <= 8'(burst_words - 1'b1);
      next_addr <= cur_addr + (ADDR_BITS'(burst_words) << BYTES_LOG2);
      rem_words <= cur_words - burst_words;
    end else if (cmd_start) begin
      next_addr <= cmd_addr;
      rem_words <= cmd_words;
    end
  end

  //////////////////////////////////////////////////
  // AW outputs
  //////////////////////////////////////////////////

  assign aw_idle       = (bursts_left == '0) && !awvalid_q;
  assign m_axi_awvalid = awvalid_q;
  assign m_axi_awaddr  = awaddr_q;
  assign m_axi_awlen   = awlen_q;
  assign m_axi_awid    = '0;
  assign m_axi_awsize  = 3'(BYTES_LOG2);
  assign m_axi_awburst = AXI_BURST_INCR;

  // New command only lands on a finished one
  assert property (@(posedge aclk) disable iff (!aresetn)
    cmd_start |-> aw_idle);

endmodule

//--- hdl/cdma_pkg.sv
package cdma_pkg;

  //////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////

  // Default data bus width, shared by AXI and stream
  localparam int unsigned AXI_DATA_BITS = 64;
  // Byte address width
  localparam int unsigned AXI_ADDR_BITS = 32;
  // Transaction ID width
  localparam int unsigned AXI_ID_BITS = 4;
  // Command length field, in bytes
  localparam int unsigned LEN_BITS = 32;

  //////////////////////////////////////////////////
  // AXI encodings
  //////////////////////////////////////////////////

  // Incrementing burst
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  // Normal access success
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Bursts needed for a word count, rounded up
  // Last burst may be short
  function automatic logic [LEN_BITS-1:0] bursts_of(
    input logic [LEN_BITS-1:0] words,
    input int unsigned         burst_len
  );
    logic [LEN_BITS-1:0] blen;
    blen = LEN_BITS'(burst_len);
    return (words + blen - 1'b1) / blen;
  endfunction

endpackage

//--- hdl/cdma_wr_top.sv
`timescale 1ns/1ps

module cdma_wr_top #(
  parameter int unsigned DATA_BITS       = cdma_pkg::AXI_DATA_BITS,
  parameter int unsigned ADDR_BITS       = cdma_pkg::AXI_ADDR_BITS,
  parameter int unsigned ID_BITS         = cdma_pkg::AXI_ID_BITS,
  parameter int unsigned BURST_LEN       = 16,
  parameter int unsigned MAX_OUTSTANDING = 8,
  parameter int unsigned QUEUE_DEPTH     = 4
) (
  input  logic                          aclk,
  input  logic                          aresetn,
  // Host commands
  input  logic                          wr_valid,
  output logic                          wr_ready,
  input  logic [ADDR_BITS-1:0]          wr_paddr,
  input  logic [cdma_pkg::LEN_BITS-1:0] wr_len,
  output logic                          wr_done,
  output logic                          wr_error,
  // AXI4 write master
  output logic                          m_axi_awvalid,
  input  logic                          m_axi_awready,
  output logic [ADDR_BITS-1:0]          m_axi_awaddr,
  output logic [ID_BITS-1:0]            m_axi_awid,
  output logic [7:0]                    m_axi_awlen,
  output logic [2:0]                    m_axi_awsize,
  output logic [1:0]                    m_axi_awburst,
  output logic [DATA_BITS-1:0]          m_axi_wdata,
  output logic [DATA_BITS/8-1:0]        m_axi_wstrb,
  output logic                          m_axi_wlast,
  output logic                          m_axi_wvalid,
  input  logic                          m_axi_wready,
  input  logic [1:0]                    m_axi_bresp,
  input  logic                          m_axi_bvalid,
  output logic                          m_axi_bready,
  // Data stream in
  input  logic [DATA_BITS-1:0]          s_axis_tdata,
  input  logic                          s_axis_tvalid,
  output logic                          s_axis_tready
);
  import cdma_pkg::*;

  // Launch bus, fanned out to all three consumers
  logic                 cmd_start;
  logic [ADDR_BITS-1:0] cmd_addr;
  logic [LEN_BITS-1:0]  cmd_words;
  // Consumer readiness and flow control
  logic                 aw_idle;
  logic                 w_idle;
  logic                 trk_space;
  logic                 aw_stall;
  logic                 aw_fire;

  assign aw_fire = m_axi_awvalid && m_axi_awready;

  //////////////////////////////////////////////////
  // Command queue
  //////////////////////////////////////////////////

  cmd_queue #(
    .DATA_BITS   (DATA_BITS),
    .ADDR_BITS   (ADDR_BITS),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_cmd_queue (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .wr_valid  (wr_valid),
    .wr_ready  (wr_ready),
    .wr_paddr  (wr_paddr),
    .wr_len    (wr_len),
    .aw_idle   (aw_idle),
    .w_idle    (w_idle),
    .trk_space (trk_space),
    .cmd_start (cmd_start),
    .cmd_addr  (cmd_addr),
    .cmd_words (cmd_words)
  );

  //////////////////////////////////////////////////
  // Channel engines and tracker
  //////////////////////////////////////////////////

  aw_burst_gen #(
    .DATA_BITS (DATA_BITS),
    .ADDR_BITS (ADDR_BITS),
    .ID_BITS   (ID_BITS),
    .BURST_LEN (BURST_LEN)
  ) u_aw_burst_gen (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .cmd_start     (cmd_start),
    .cmd_addr      (cmd_addr),
    .cmd_words     (cmd_words),
    .aw_stall      (aw_stall),
    .aw_idle       (aw_idle),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_awid    (m_axi_awid),
    .m_axi_awlen   (m_axi_awlen),
    .m_axi_awsize  (m_axi_awsize),
    .m_axi_awburst (m_axi_awburst)
  );

  // Data side runs alongside AW on the same command
  w_beat_gen #(
    .DATA_BITS (DATA_BITS),
    .BURST_LEN (BURST_LEN)
  ) u_w_beat_gen (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .cmd_start     (cmd_start),
    .cmd_words     (cmd_words),
    .w_idle        (w_idle),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wstrb   (m_axi_wstrb),
    .m_axi_wlast   (m_axi_wlast),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready)
  );

  wr_completion #(
    .BURST_LEN       (BURST_LEN),
    .MAX_OUTSTANDING (MAX_OUTSTANDING),
    .QUEUE_DEPTH     (QUEUE_DEPTH)
  ) u_wr_completion (
    .aclk         (aclk),
    .aresetn      (aresetn),
    .cmd_start    (cmd_start),
    .cmd_words    (cmd_words),
    .aw_fire      (aw_fire),
    .trk_space    (trk_space),
    .aw_stall     (aw_stall),
    .m_axi_bresp  (m_axi_bresp),
    .m_axi_bvalid (m_axi_bvalid),
    .m_axi_bready (m_axi_bready),
    .wr_done      (wr_done),
    .wr_error     (wr_error)
  );

endmodule

//--- hdl/cmd_queue.sv
`timescale 1ns/1ps

module cmd_queue #(
  parameter int unsigned DATA_BITS   = cdma_pkg::AXI_DATA_BITS,
  parameter int unsigned ADDR_BITS   = cdma_pkg::AXI_ADDR_BITS,
  parameter int unsigned QUEUE_DEPTH = 4
) (
  input  logic                          aclk,
  input  logic                          aresetn,
  // Host command side
  input  logic                          wr_valid,
  output logic                          wr_ready,
  input  logic [ADDR_BITS-1:0]          wr_paddr,
  input  logic [cdma_pkg::LEN_BITS-1:0] wr_len,
  // Consumer readiness
  input  logic                          aw_idle,
  input  logic                          w_idle,
  input  logic                          trk_space,
  // Launch strobe, no back-pressure
  output logic                          cmd_start,
  output logic [ADDR_BITS-1:0]          cmd_addr,
  output logic [cdma_pkg::LEN_BITS-1:0] cmd_words
);
  import cdma_pkg::*;

  localparam int unsigned BYTES_LOG2 = $clog2(DATA_BITS / 8);
  localparam int unsigned PTR_BITS   = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int unsigned CNT_BITS   = $clog2(QUEUE_DEPTH + 1);

  // Entry storage
  logic [ADDR_BITS-1:0] addr_mem  [QUEUE_DEPTH];
  logic [LEN_BITS-1:0]  words_mem [QUEUE_DEPTH];
  logic [PTR_BITS-1:0]  wr_ptr;
  logic [PTR_BITS-1:0]  rd_ptr;
  logic [CNT_BITS-1:0]  count;
  logic                 push;

  assign wr_ready = (count != CNT_BITS'(QUEUE_DEPTH));
  assign push     = wr_valid && wr_ready;

  // Head leaves only when every consumer can latch it
  assign cmd_start = (count != '0) && aw_idle && w_idle && trk_space;
  assign cmd_addr  = addr_mem[rd_ptr];
  assign cmd_words = words_mem[rd_ptr];

  // Length stored as words, low bytes are zero anyway
  always_ff @(posedge aclk) begin
    if (push) begin
      addr_mem[wr_ptr]  <= wr_paddr;
      words_mem[wr_ptr] <= wr_len >> BYTES_LOG2;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at depth, any depth allowed
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (cmd_start) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, cmd_start})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Occupancy never runs past the entry count
  assert property (@(posedge aclk) disable iff (!aresetn)
    count <= CNT_BITS'(QUEUE_DEPTH));

endmodule

//--- hdl/w_beat_gen.sv
`timescale 1ns/1ps

module w_beat_gen #(
  parameter int unsigned DATA_BITS = cdma_pkg::AXI_DATA_BITS,
  parameter int unsigned BURST_LEN = 16
) (
  input  logic                          aclk,
  input  logic                          aresetn,
  // Command latch
  input  logic                          cmd_start,
  input  logic [cdma_pkg::LEN_BITS-1:0] cmd_words,
  output logic                          w_idle,
  // Input stream
  input  logic [DATA_BITS-1:0]          s_axis_tdata,
  input  logic                          s_axis_tvalid,
  output logic                          s_axis_tready,
  // W channel
  output logic [DATA_BITS-1:0]          m_axi_wdata,
  output logic [DATA_BITS/8-1:0]        m_axi_wstrb,
  output logic                          m_axi_wlast,
  output logic                          m_axi_wvalid,
  input  logic                          m_axi_wready
);
  import cdma_pkg::*;

  localparam int unsigned BEAT_BITS = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;

  // Words still owed for this command
  logic [LEN_BITS-1:0]  rem_words;
  // Position inside the current burst
  logic [BEAT_BITS-1:0] beat_cnt;
  logic                 busy;
  logic                 w_fire;

  //////////////////////////////////////////////////
  // Stream to W pass-through
  //////////////////////////////////////////////////

  assign busy   = (rem_words != '0);
  assign w_idle = !busy;

  // Handshake gated by busy only, no skid buffer
  assign m_axi_wvalid  = busy && s_axis_tvalid;
  assign s_axis_tready = busy && m_axi_wready;
  assign m_axi_wdata   = s_axis_tdata;
  // Aligned, full words only
  assign m_axi_wstrb   = '1;

  // End of full burst or end of command
  assign m_axi_wlast = (beat_cnt == BEAT_BITS'(BURST_LEN - 1)) ||
                       (rem_words == LEN_BITS'(1));

  assign w_fire = m_axi_wvalid && m_axi_wready;

  //////////////////////////////////////////////////
  // Beat counters
  //////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rem_words <= '0;
      beat_cnt  <= '0;
    end else if (cmd_start) begin
      rem_words <= cmd_words;
      beat_cnt  <= '0;
    end else if (w_fire) begin
      rem_words <= rem_words - 1'b1;
      // Restart count at each burst boundary
      beat_cnt  <= m_axi_wlast ? '0 : beat_cnt + 1'b1;
    end
  end

  // Launch never cuts into words still owed
  assert property (@(posedge aclk) disable iff (!aresetn)
    cmd_start |-> w_idle);

endmodule

//--- hdl/wr_completion.sv
`timescale 1ns/1ps

module wr_completion #(
  parameter int unsigned BURST_LEN       = 16,
  parameter int unsigned MAX_OUTSTANDING = 8,
  parameter int unsigned QUEUE_DEPTH     = 4
) (
  input  logic                          aclk,
  input  logic                          aresetn,
  // Command latch
  input  logic                          cmd_start,
  input  logic [cdma_pkg::LEN_BITS-1:0] cmd_words,
  // AW progress and flow control
  input  logic                          aw_fire,
  output logic                          trk_space,
  output logic                          aw_stall,
  // B channel
  input  logic [1:0]                    m_axi_bresp,
  input  logic                          m_axi_bvalid,
  output logic                          m_axi_bready,
  // Status
  output logic                          wr_done,
  output logic                          wr_error
);
  import cdma_pkg::*;

  localparam int unsigned OUT_BITS = $clog2(MAX_OUTSTANDING + 1);
  localparam int unsigned PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int unsigned CNT_BITS = $clog2(QUEUE_DEPTH + 1);

  // Bursts per launched command, oldest at rd_ptr
  logic [LEN_BITS-1:0] bursts_mem [QUEUE_DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  // Responses seen for the head command
  logic [LEN_BITS-1:0] acked;
  logic [OUT_BITS-1:0] outstanding;
  logic [OUT_BITS-1:0] out_next;
  logic                bready_q;
  logic                b_fire;
  logic                head_done;

  assign m_axi_bready = bready_q;
  assign b_fire       = m_axi_bvalid && bready_q;
  assign trk_space    = (count != CNT_BITS'(QUEUE_DEPTH));
  // Single ID, so responses return in issue order
  assign head_done    = b_fire && ((acked + 1'b1) == bursts_mem[rd_ptr]);

  // Stall on next cycle's count, AW valid is a register behind this
  always_comb begin
    out_next = outstanding + OUT_BITS'(aw_fire) - OUT_BITS'(b_fire);
    aw_stall = (out_next == OUT_BITS'(MAX_OUTSTANDING));
  end

  always_ff @(posedge aclk) begin
    if (cmd_start) begin
      bursts_mem[wr_ptr] <= bursts_of(cmd_words, BURST_LEN);
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      bready_q    <= 1'b0;
      outstanding <= '0;
      acked       <= '0;
      wr_done     <= 1'b0;
      wr_error    <= 1'b0;
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
    end else begin
      bready_q    <= 1'b1;
      outstanding <= out_next;
      wr_done     <= head_done;
      // Sticky on any non-OKAY
      if (b_fire && (m_axi_bresp != AXI_RESP_OKAY)) begin
        wr_error <= 1'b1;
      end
      if (head_done) begin
        acked <= '0;
      end else if (b_fire) begin
        acked <= acked + 1'b1;
      end
      if (cmd_start) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (head_done) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({cmd_start, head_done})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Slave answers only bursts the AW side has issued
  assert property (@(posedge aclk) disable iff (!aresetn)
    b_fire |-> (outstanding != '0));

endmodule

//--- list.f
hdl/cdma_pkg.sv
hdl/cmd_queue.sv
hdl/aw_burst_gen.sv
hdl/w_beat_gen.sv
hdl/wr_completion.sv
hdl/cdma_wr_top.sv
sim/tb_cdma_wr.sv

//--- sim/tb_cdma_wr.sv
`timescale 1ns/1ps

module tb_cdma_wr;

  localparam int unsigned DATA_BITS       = 64;
  localparam int unsigned ADDR_BITS       = 32;
  localparam int unsigned ID_BITS         = 4;
  localparam int unsigned BURST_LEN       = 4;
  localparam int unsigned MAX_OUTSTANDING = 3;
  localparam int unsigned QUEUE_DEPTH     = 4;
  localparam int unsigned NUM_CMDS        = 24;
  localparam int unsigned MAX_WORDS       = 15;
  // Worst case per command plus reset and drain margin
  localparam int unsigned CYCLE_LIMIT     = 200 * NUM_CMDS + 1000;

  logic                   aclk;
  logic                   aresetn;
  logic                   wr_valid;
  logic                   wr_ready;
  logic [ADDR_BITS-1:0]   wr_paddr;
  logic [31:0]            wr_len;
  logic                   wr_done;
  logic                   wr_error;
  logic                   m_axi_awvalid;
  logic                   m_axi_awready;
  logic [ADDR_BITS-1:0]   m_axi_awaddr;
  logic [ID_BITS-1:0]     m_axi_awid;
  logic [7:0]             m_axi_awlen;
  logic [2:0]             m_axi_awsize;
  logic [1:0]             m_axi_awburst;
  logic [DATA_BITS-1:0]   m_axi_wdata;
  logic [DATA_BITS/8-1:0] m_axi_wstrb;
  logic                   m_axi_wlast;
  logic                   m_axi_wvalid;
  logic                   m_axi_wready;
  logic [1:0]             m_axi_bresp;
  logic                   m_axi_bvalid;
  logic                   m_axi_bready;
  logic [DATA_BITS-1:0]   s_axis_tdata;
  logic                   s_axis_tvalid;
  logic                   s_axis_tready;

  //////////////////////////////////////////////////
  // Reference model and slave state
  //////////////////////////////////////////////////

  logic [31:0] lcg_state;
  // Commands in issue order
  logic [31:0] cmd_addr_q [$];
  logic [31:0] cmd_len_q [$];
  // Expected AW sequence
  logic [31:0] exp_awaddr_q [$];
  logic [7:0]  exp_awlen_q [$];
  // Running burst total at the end of each command
  int unsigned done_mark_q [$];
  logic [63:0] stream_q [$];
  logic [63:0] exp_mem [int unsigned];
  // Slave memory, keyed by word address
  logic [63:0] mem [int unsigned];
  // Accepted AW bursts still waiting for their W data
  logic [31:0] aw_seen_addr_q [$];
  logic [7:0]  aw_seen_len_q [$];
  logic [63:0] wbeat_q [$];
  int unsigned wburst_q [$];
  logic [1:0]  bpend_q [$];
  int unsigned beat_cnt;
  int unsigned outstanding;
  int unsigned b_total;
  int unsigned b_issued;
  int unsigned err_idx;
  int unsigned dones;
  int unsigned cycles;
  int unsigned accepted;
  int unsigned accept_cycle;
  logic        exp_done;
  logic        exp_error;
  logic        first_aw_seen;
  logic        took_cmd;
  logic        took_beat;
  logic        took_b;

  cdma_wr_top #(
    .DATA_BITS       (DATA_BITS),
    .ADDR_BITS       (ADDR_BITS),
    .ID_BITS         (ID_BITS),
    .BURST_LEN       (BURST_LEN),
    .MAX_OUTSTANDING (MAX_OUTSTANDING),
    .QUEUE_DEPTH     (QUEUE_DEPTH)
  ) u_dut (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .wr_valid      (wr_valid),
    .wr_ready      (wr_ready),
    .wr_paddr      (wr_paddr),
    .wr_len        (wr_len),
    .wr_done       (wr_done),
    .wr_error      (wr_error),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_awid    (m_axi_awid),
    .m_axi_awlen   (m_axi_awlen),
    .m_axi_awsize  (m_axi_awsize),
    .m_axi_awburst (m_axi_awburst),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wstrb   (m_axi_wstrb),
    .m_axi_wlast   (m_axi_wlast),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_bresp   (m_axi_bresp),
    .m_axi_bvalid  (m_axi_bvalid),
    .m_axi_bready  (m_axi_bready),
    .s_axis_tdata  (s_axis_tdata),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready)
  );

  initial begin
    aclk = 1'b0;
    forever #5 aclk = ~aclk;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // High bits, low LCG bits cycle too fast
  function automatic int unsigned pick(input int unsigned n);
    logic [31:0] r;
    r = lcg_next();
    return (r >> 16) % n;
  endfunction

  task automatic expect_eq(input string name, input logic [63:0] exp_val,
                           input logic [63:0] act_val);
    if (exp_val !== act_val) begin
      $display("error: %s expected %0h actual %0h", name, exp_val, act_val);
      $display("Some tests failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus generation
  //////////////////////////////////////////////////

  task automatic build_commands();
    logic [31:0] addr;
    logic [31:0] baddr;
    logic [63:0] word;
    int unsigned words;
    int unsigned left;
    int unsigned blen;
    int unsigned bursts;
    addr   = 32'h0001_0000;
    bursts = 0;
    for (int c = 0; c < NUM_CMDS; c++) begin
      words = 1 + pick(MAX_WORDS);
      cmd_addr_q.push_back(addr);
      cmd_len_q.push_back(words * 8);
      // Full bursts, then a short tail
      left  = words;
      baddr = addr;
      while (left != 0) begin
        blen = (left < BURST_LEN) ? left : BURST_LEN;
        exp_awaddr_q.push_back(baddr);
        exp_awlen_q.push_back(8'(blen - 1));
        baddr  = baddr + 32'(blen * 8);
        left   = left - blen;
        bursts = bursts + 1;
      end
      done_mark_q.push_back(bursts);
      // Stream words land in order from the command base
      for (int i = 0; i < words; i++) begin
        word[63:32] = lcg_next();
        word[31:0]  = lcg_next();
        stream_q.push_back(word);
        exp_mem[(addr >> 3) + 32'(i)] = word;
      end
      // Next base on a burst boundary, random gap
      addr = addr + 32'(((words + BURST_LEN - 1) / BURST_LEN + pick(3)) * BURST_LEN * 8);
    end
    // Last burst of the run gets SLVERR
    err_idx = bursts - 1;
  endtask

  // Falling edge only, held valids stay until taken
  task automatic drive_inputs();
    if (!wr_valid || took_cmd) begin
      wr_valid = (accepted < NUM_CMDS) && (pick(4) != 0);
      if (wr_valid) begin
        wr_paddr = cmd_addr_q[accepted];
        wr_len   = cmd_len_q[accepted];
      end
    end
    if (!s_axis_tvalid || took_beat) begin
      s_axis_tvalid = (stream_q.size() != 0) && (pick(4) != 0);
      if (s_axis_tvalid) begin
        s_axis_tdata = stream_q[0];
      end
    end
    if (!m_axi_bvalid || took_b) begin
      m_axi_bvalid = (bpend_q.size() != 0) && (pick(2) != 0);
      if (m_axi_bvalid) begin
        m_axi_bresp = bpend_q[0];
      end
    end
    m_axi_awready = (pick(2) != 0);
    m_axi_wready  = (pick(4) != 0);
  endtask

  //////////////////////////////////////////////////
  // Sampling, one settled point per cycle
  //////////////////////////////////////////////////

  task automatic observe();
    logic [31:0] addr;
    logic [7:0]  len;
    int unsigned nbeats;
    // Registered status from the last edge
    expect_eq("wr_done", 64'(exp_done), 64'(wr_done));
    expect_eq("wr_error", 64'(exp_error), 64'(wr_error));
    expect_eq("bready", 64'd1, 64'(m_axi_bready));
    if (wr_done) begin
      dones = dones + 1;
    end
    exp_done = 1'b0;
    took_cmd = wr_valid && wr_ready;
    if (took_cmd) begin
      if (accepted == 0) begin
        accept_cycle = cycles;
      end
      accepted = accepted + 1;
    end
    // Empty queue, idle engine, launch one cycle after accept
    if (m_axi_awvalid && !first_aw_seen) begin
      first_aw_seen = 1'b1;
      expect_eq("first_aw_latency", 64'(accept_cycle + 2), 64'(cycles));
    end
    // B before AW, both may land on the same edge
    took_b = m_axi_bvalid && m_axi_bready;
    if (took_b) begin
      if (bpend_q[0] != 2'b00) begin
        exp_error = 1'b1;
      end
      void'(bpend_q.pop_front());
      b_total     = b_total + 1;
      outstanding = outstanding - 1;
      if (done_mark_q.size() != 0 && b_total == done_mark_q[0]) begin
        exp_done = 1'b1;
        void'(done_mark_q.pop_front());
      end
    end
    if (m_axi_awvalid && m_axi_awready) begin
      if (exp_awaddr_q.size() == 0) begin
        $display("AW burst issued after all expected bursts were seen");
        $display("Some tests failed");
        $fatal(1, "unexpected AW burst");
      end
      expect_eq("awaddr", 64'(exp_awaddr_q[0]), 64'(m_axi_awaddr));
      expect_eq("awlen", 64'(exp_awlen_q[0]), 64'(m_axi_awlen));
      expect_eq("awsize", 64'd3, 64'(m_axi_awsize));
      // INCR
      expect_eq("awburst", 64'd1, 64'(m_axi_awburst));
      expect_eq("awid", 64'd0, 64'(m_axi_awid));
      aw_seen_addr_q.push_back(exp_awaddr_q.pop_front());
      aw_seen_len_q.push_back(exp_awlen_q.pop_front());
      outstanding = outstanding + 1;
    end
    expect_eq("outstanding_limit", 64'd1, 64'(outstanding <= MAX_OUTSTANDING));
    if (m_axi_wvalid && m_axi_wready) begin
      expect_eq("wstrb", 64'hff, 64'(m_axi_wstrb));
      wbeat_q.push_back(m_axi_wdata);
      beat_cnt = beat_cnt + 1;
      if (m_axi_wlast) begin
        wburst_q.push_back(beat_cnt);
        beat_cnt = 0;
      end
    end
    took_beat = s_axis_tvalid && s_axis_tready;
    if (took_beat) begin
      void'(stream_q.pop_front());
    end
    // Pair finished W bursts with AW, in order, then queue a B
    while (aw_seen_addr_q.size() != 0 && wburst_q.size() != 0) begin
      nbeats = wburst_q.pop_front();
      addr   = aw_seen_addr_q.pop_front();
      len    = aw_seen_len_q.pop_front();
      expect_eq("w_burst_beats", 64'(len) + 64'd1, 64'(nbeats));
      for (int i = 0; i < nbeats; i++) begin
        mem[(addr >> 3) + 32'(i)] = wbeat_q.pop_front();
      end
      bpend_q.push_back((b_issued == err_idx) ? 2'b10 : 2'b00);
      b_issued = b_issued + 1;
    end
  endtask

  task automatic final_checks();
    expect_eq("done_count", 64'(NUM_CMDS), 64'(dones));
    expect_eq("aw_left", 64'd0, 64'(exp_awaddr_q.size()));
    expect_eq("stream_left", 64'd0, 64'(stream_q.size()));
    expect_eq("wbeats_left", 64'd0, 64'(wbeat_q.size()));
    expect_eq("wr_error_final", 64'd1, 64'(wr_error));
    expect_eq("mem_words", 64'(exp_mem.num()), 64'(mem.num()));
    foreach (exp_mem[k]) begin
      expect_eq("mem_written", 64'd1, 64'(mem.exists(k)));
      expect_eq("mem_data", exp_mem[k], mem[k]);
    end
  endtask

  initial begin
    aresetn       = 1'b0;
    wr_valid      = 1'b0;
    wr_paddr      = '0;
    wr_len        = '0;
    m_axi_awready = 1'b0;
    m_axi_wready  = 1'b0;
    m_axi_bresp   = 2'b00;
    m_axi_bvalid  = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tvalid = 1'b0;
    lcg_state     = 32'hbd8e277c;
    beat_cnt      = 0;
    outstanding   = 0;
    b_total       = 0;
    b_issued      = 0;
    dones         = 0;
    cycles        = 0;
    accepted      = 0;
    accept_cycle  = 0;
    exp_done      = 1'b0;
    exp_error     = 1'b0;
    first_aw_seen = 1'b0;
    took_cmd      = 1'b0;
    took_beat     = 1'b0;
    took_b        = 1'b0;
    build_commands();
    repeat (8) @(posedge aclk);
    @(negedge aclk);
    // Reset values
    expect_eq("rst_awvalid", 64'd0, 64'(m_axi_awvalid));
    expect_eq("rst_wvalid", 64'd0, 64'(m_axi_wvalid));
    expect_eq("rst_tready", 64'd0, 64'(s_axis_tready));
    expect_eq("rst_wr_done", 64'd0, 64'(wr_done));
    expect_eq("rst_wr_error", 64'd0, 64'(wr_error));
    expect_eq("rst_wr_ready", 64'd1, 64'(wr_ready));
    aresetn = 1'b1;
    while (dones != NUM_CMDS && cycles < CYCLE_LIMIT) begin
      @(negedge aclk);
      drive_inputs();
      #1;
      observe();
      cycles = cycles + 1;
    end
    if (dones != NUM_CMDS) begin
      $display("timeout with %0d of %0d commands done after %0d cycles",
               dones, NUM_CMDS, cycles);
      $display("Some tests failed");
      $fatal(1, "run hit the cycle limit");
    end else begin
      final_checks();
      $display("All tests passed");
      $finish;
    end
  end

endmodule
